// ==== Makefile ====
TOP = tetris_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f all.f -o sim

run: build
	out=$$(./obj_dir/sim); \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f all.f

clean:
	rm -rf obj_dir

// ==== all.f ====
verilog/tetris_pkg.sv
verilog/playfield_row.sv
verilog/piece_renderer.sv
verilog/landing_collector.sv
verilog/game_fsm.sv
verilog/tetris_top.sv
bench/tetris_checker.sv
bench/tetris_tb.sv

// ==== bench/tetris_checker.sv ====
`timescale 1ns/1ps

module tetris_checker #(
    parameter int ROWS = 20,
    parameter int COLS = 10
) (
    input logic                      clk,
    input logic                      reset,
    input logic                      piece_valid,
    input logic                      piece_ready,
    input logic                      game_over,
    input logic [ROWS-1:0][COLS-1:0] display
);

    // ready means spawn, game over is a separate state
    ready_not_over: assert property (@(posedge clk) disable iff (reset)
        !(piece_ready && game_over))
        else $error("piece_ready and game_over are high in the same cycle");

    // only reset leaves game over
    over_sticky: assert property (@(posedge clk) disable iff (reset)
        game_over |=> game_over)
        else $error("game_over dropped without reset");

    // idle spawn cycle, nothing stored or falling can change
    spawn_idle_stable: assert property (@(posedge clk) disable iff (reset)
        (piece_ready && !piece_valid) |=> $stable(display))
        else $error("display changed after a spawn cycle with no acceptance");

endmodule

bind tetris_top tetris_checker #(.ROWS(ROWS), .COLS(COLS)) u_checker (
    .clk         (clk),
    .reset       (reset),
    .piece_valid (piece_valid),
    .piece_ready (piece_ready),
    .game_over   (game_over),
    .display     (display)
);

// ==== bench/tetris_tb.sv ====
`timescale 1ns/1ps

module tetris_tb;
    import tetris_pkg::*;

    localparam int ROWS = 20;
    localparam int COLS = 10;
    localparam int RUNS = 2;
    localparam int MAX_PIECES = 60;
    localparam int OVER_IDLE = 20;
    // runs x pieces x cycles per piece x margin
    localparam int TIMEOUT_CYCLES = RUNS * MAX_PIECES * 25 * 4;

    // model states
    localparam int S_SPAWN = 0;
    localparam int S_FALL  = 1;
    localparam int S_MERGE = 2;
    localparam int S_OVER  = 3;

    typedef logic [ROWS-1:0][COLS-1:0] board_t;

    logic        clk;
    logic        reset;
    logic        piece_valid;
    piece_type_t piece_type;
    logic        piece_ready;
    logic        drop;
    board_t      display;
    logic        game_over;

    // reference model of the playfield
    board_t      m_board;
    int          m_state;
    piece_type_t m_type;
    int          m_row;

    int         mismatches;
    int         failures;
    int         cycle_count;
    int         game_overs;
    logic [7:0] seen_types;

    tetris_top #(.ROWS(ROWS), .COLS(COLS)) dut (
        .clk         (clk),
        .reset       (reset),
        .piece_valid (piece_valid),
        .piece_type  (piece_type),
        .piece_ready (piece_ready),
        .drop        (drop),
        .display     (display),
        .game_over   (game_over)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // four cells per shape, one byte each
    // high nibble row offset from the top, low nibble board column
    function automatic logic [31:0] shape_word(input piece_type_t kind);
        case (kind)
            SMASHBOY:  return 32'h04051415;
            L_PIECE:   return 32'h04142425;
            REVERSE_L: return 32'h05152524;
            S_PIECE:   return 32'h05061415;
            Z_PIECE:   return 32'h04051516;
            T_PIECE:   return 32'h04131415;
            default:   return 32'h04142434;
        endcase
    endfunction

    // piece drawn with its top at row top, cells past the bottom dropped
    function automatic board_t render(input piece_type_t kind, input int top);
        board_t      b;
        logic [31:0] cells;
        int          r;
        int          c;
        b = '0;
        cells = shape_word(kind);
        for (int k = 0; k < 4; k++) begin
            r = top + int'(cells[31-8*k -: 4]);
            c = int'(cells[27-8*k -: 4]);
            if (r < ROWS) begin
                b[r][c] = 1'b1;
            end
        end
        return b;
    endfunction

    // off the bottom or on top of a stored cell
    function automatic logic collides(input piece_type_t kind, input int top);
        logic [31:0] cells;
        logic        hit;
        int          r;
        int          c;
        hit = 1'b0;
        cells = shape_word(kind);
        for (int k = 0; k < 4; k++) begin
            r = top + int'(cells[31-8*k -: 4]);
            c = int'(cells[27-8*k -: 4]);
            if (r >= ROWS) begin
                hit = 1'b1;
            end else if (m_board[r][c]) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    task automatic model_clear();
        m_board = '0;
        m_state = S_SPAWN;
        m_type  = LINE;
        m_row   = 0;
    endtask

    // one clock edge, with the inputs the DUT saw at that edge
    task automatic model_step();
        case (m_state)
            S_SPAWN: begin
                if (piece_valid) begin
                    if (collides(piece_type, 0)) begin
                        m_state = S_OVER;
                        game_overs++;
                    end else begin
                        m_state = S_FALL;
                        m_type  = piece_type;
                        m_row   = 0;
                    end
                end
            end
            S_FALL: begin
                if (drop) begin
                    if (collides(m_type, m_row + 1)) begin
                        m_state = S_MERGE;
                    end else begin
                        m_row++;
                    end
                end
            end
            S_MERGE: begin
                m_board = m_board | render(m_type, m_row);
                m_state = S_SPAWN;
            end
            default: begin
                // game over, offers and drops ignored
            end
        endcase
    endtask

    task automatic check_outputs();
        board_t exp_display;
        logic   exp_ready;
        logic   exp_over;
        exp_display = m_board;
        if (m_state == S_FALL || m_state == S_MERGE) begin
            exp_display = exp_display | render(m_type, m_row);
        end
        exp_ready = (m_state == S_SPAWN);
        exp_over  = (m_state == S_OVER);
        if (display !== exp_display) begin
            $display("MISMATCH display: got %h expected %h", display, exp_display);
            mismatches++;
        end
        if (piece_ready !== exp_ready) begin
            $display("MISMATCH piece_ready: got %h expected %h", piece_ready, exp_ready);
            mismatches++;
        end
        if (game_over !== exp_over) begin
            $display("MISMATCH game_over: got %h expected %h", game_over, exp_over);
            mismatches++;
        end
    endtask

    // offer held until accepted, random gaps, drop about half the cycles
    task automatic drive_stimulus(input logic was_accept);
        drop <= 1'($urandom % 2);
        if (was_accept) begin
            piece_valid <= 1'b0;
        end else if (!piece_valid && ($urandom % 3 == 0)) begin
            piece_valid <= 1'b1;
            piece_type  <= piece_type_t'(3'($urandom % 7));
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        reset       <= 1'b1;
        piece_valid <= 1'b0;
        drop        <= 1'b0;
        model_clear();
        repeat (2) begin
            @(negedge clk);
            check_outputs();
            @(posedge clk);
        end
        reset <= 1'b0;
    endtask

    task automatic print_counts();
        $display("result: %0d mismatches, %0d other errors, %0d cycles",
                 mismatches, failures, cycle_count);
    endtask

    initial begin
        logic took;
        int   accepted;
        int   over_cycles;
        reset       = 1'b1;
        piece_valid = 1'b0;
        piece_type  = LINE;
        drop        = 1'b0;
        mismatches  = 0;
        failures    = 0;
        game_overs  = 0;
        seen_types  = '0;
        void'($urandom(32'h38df));
        model_clear();
        for (int run = 0; run < RUNS; run++) begin
            apply_reset();
            accepted    = 0;
            over_cycles = 0;
            while (accepted < MAX_PIECES && over_cycles < OVER_IDLE) begin
                @(negedge clk);
                check_outputs();
                @(posedge clk);
                took = (m_state == S_SPAWN) && piece_valid;
                if (took) begin
                    accepted++;
                    seen_types[piece_type] = 1'b1;
                end
                if (m_state == S_OVER) begin
                    over_cycles++;
                end
                model_step();
                drive_stimulus(took);
            end
            // outputs after the last edge of the run
            @(negedge clk);
            check_outputs();
        end
        if (seen_types[6:0] != 7'h7f) begin
            $display("not every piece type was accepted, seen mask %h", seen_types);
            failures++;
        end
        if (game_overs == 0) begin
            $display("game over was never reached in any run");
            failures++;
        end
        print_counts();
        if (mismatches == 0 && failures == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // watchdog on total cycles
    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        print_counts();
        $display("TESTS FAILED");
        $finish;
    end

endmodule

// ==== verilog/game_fsm.sv ====
`timescale 1ns/1ps

module game_fsm #(
    parameter int ROWS = 20,
    localparam int ROW_W = $clog2(ROWS + tetris_pkg::PIECE_SPAN)
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    piece_valid,
    input  tetris_pkg::piece_type_t piece_type,
    input  logic                    drop,
    input  logic                    blocked,
    output logic                    piece_ready,
    output tetris_pkg::piece_type_t cur_type,
    output logic [ROW_W-1:0]        cur_row,
    output logic                    piece_active,
    output tetris_pkg::piece_type_t probe_type,
    output logic [ROW_W-1:0]        probe_row,
    output logic                    merge,
    output logic                    game_over
);
    import tetris_pkg::*;

    // controller states
    localparam logic [1:0] SPAWN     = 2'd0;
    localparam logic [1:0] FALLING   = 2'd1;
    localparam logic [1:0] MERGE     = 2'd2;
    localparam logic [1:0] GAME_OVER = 2'd3;

    logic [1:0] state;
    logic [1:0] state_next;
    logic       accept;
    logic       step;

    // ready only waits on the state, never on valid
    assign piece_ready = (state == SPAWN);
    assign accept      = piece_valid && piece_ready;

    // free drop, the piece moves one row down
    assign step = (state == FALLING) && drop && !blocked;

    assign merge        = (state == MERGE);
    assign game_over    = (state == GAME_OVER);
    // piece still drawn during merge so display does not blink
    assign piece_active = (state == FALLING) || (state == MERGE);

    // probe selection
    // spawn checks the offered piece at the top row
    // falling checks the piece one row below where it is now
    assign probe_type = (state == SPAWN) ? piece_type : cur_type;
    assign probe_row  = (state == SPAWN) ? '0 : cur_row + ROW_W'(1);

    always_comb begin
        state_next = state;
        case (state)
            SPAWN: begin
                // spawn spot already taken ends the game
                if (accept) begin
                    state_next = blocked ? GAME_OVER : FALLING;
                end
            end
            FALLING: begin
                if (drop && blocked) begin
                    state_next = MERGE;
                end
            end
            MERGE: begin
                // rows take the piece on this edge
                state_next = SPAWN;
            end
            default: begin
                // game over holds until reset
                state_next = GAME_OVER;
            end
        endcase
    end

    // type and top row of the piece in play
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= SPAWN;
            cur_row  <= '0;
            cur_type <= LINE;
        end else begin
            state <= state_next;
            if (accept) begin
                cur_row  <= '0;
                cur_type <= piece_type;
            end else if (step) begin
                cur_row <= cur_row + ROW_W'(1);
            end
        end
    end

endmodule

// ==== verilog/landing_collector.sv ====
`timescale 1ns/1ps

module landing_collector #(
    parameter int ROWS = 20,
    parameter int COLS = 10
) (
    input  logic [ROWS-1:0]           row_hit,
    input  logic                      probe_off_board,
    input  logic [COLS-1:0]           display_rows [ROWS],
    output logic                      blocked,
    output logic [ROWS-1:0][COLS-1:0] display
);

    // one overlap anywhere on the board stops the probe
    // running off the bottom counts the same as hitting the stack
    assign blocked = (|row_hit) || probe_off_board;

    // pack row outputs into the display bus
    // index 0 is the top row
    always_comb begin
        display = '0;
        for (int r = 0; r < ROWS; r++) begin
            display[r] = display_rows[r];
        end
    end

endmodule

// ==== verilog/piece_renderer.sv ====
`timescale 1ns/1ps

module piece_renderer #(
    parameter int ROWS = 20,
    parameter int COLS = 10,
    localparam int ROW_W = $clog2(ROWS + tetris_pkg::PIECE_SPAN)
) (
    input  tetris_pkg::piece_type_t       cur_type,
    input  logic [ROW_W-1:0]              cur_row,
    input  logic                          piece_active,
    input  tetris_pkg::piece_type_t       probe_type,
    input  logic [ROW_W-1:0]              probe_row,
    output logic [ROWS-1:0][COLS-1:0]     cur_bits,
    output logic [ROWS-1:0][COLS-1:0]     probe_bits,
    output logic                          probe_off_board
);
    import tetris_pkg::*;

    // shape boxes in spawn coordinates, box row 0 is the top of the piece
    logic [PIECE_SPAN-1:0][COLS-1:0] cur_shape;
    logic [PIECE_SPAN-1:0][COLS-1:0] probe_shape;

    // shape table, bit c of a box row is board column c
    function automatic logic [PIECE_SPAN-1:0][COLS-1:0] shape_of(input piece_type_t kind);
        logic [PIECE_SPAN-1:0][COLS-1:0] s;
        s = '0;
        case (kind)
            SMASHBOY: begin
                s[0][4] = 1'b1;
                s[0][5] = 1'b1;
                s[1][4] = 1'b1;
                s[1][5] = 1'b1;
            end
            L_PIECE: begin
                s[0][4] = 1'b1;
                s[1][4] = 1'b1;
                s[2][4] = 1'b1;
                s[2][5] = 1'b1;
            end
            REVERSE_L: begin
                s[0][5] = 1'b1;
                s[1][5] = 1'b1;
                s[2][5] = 1'b1;
                s[2][4] = 1'b1;
            end
            S_PIECE: begin
                s[0][5] = 1'b1;
                s[0][6] = 1'b1;
                s[1][4] = 1'b1;
                s[1][5] = 1'b1;
            end
            Z_PIECE: begin
                s[0][4] = 1'b1;
                s[0][5] = 1'b1;
                s[1][5] = 1'b1;
                s[1][6] = 1'b1;
            end
            T_PIECE: begin
                s[0][4] = 1'b1;
                s[1][3] = 1'b1;
                s[1][4] = 1'b1;
                s[1][5] = 1'b1;
            end
            default: begin
                // LINE, and the unused code 7 lands here too
                s[0][4] = 1'b1;
                s[1][4] = 1'b1;
                s[2][4] = 1'b1;
                s[3][4] = 1'b1;
            end
        endcase
        return s;
    endfunction

    assign cur_shape   = shape_of(cur_type);
    assign probe_shape = shape_of(probe_type);

    // place each box with its top at the given row
    always_comb begin
        cur_bits   = '0;
        probe_bits = '0;
        for (int r = 0; r < ROWS; r++) begin
            for (int k = 0; k < PIECE_SPAN; k++) begin
                // falling piece, hidden when nothing is in play
                if (piece_active && r == int'(cur_row) + k) begin
                    cur_bits[r] = cur_bits[r] | cur_shape[k];
                end
                // candidate position for the collision check
                if (r == int'(probe_row) + k) begin
                    probe_bits[r] = probe_bits[r] | probe_shape[k];
                end
            end
        end
    end

    // any filled box row that would sit past the last board row
    // those cells are simply not drawn above
    always_comb begin
        probe_off_board = 1'b0;
        for (int k = 0; k < PIECE_SPAN; k++) begin
            if (probe_shape[k] != '0 && int'(probe_row) + k >= ROWS) begin
                probe_off_board = 1'b1;
            end
        end
    end

endmodule

// ==== verilog/playfield_row.sv ====
`timescale 1ns/1ps

module playfield_row #(
    parameter int COLS = 10
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            merge,
    input  logic [COLS-1:0] cur_bits,
    input  logic [COLS-1:0] probe_bits,
    output logic            hit,
    output logic [COLS-1:0] display_row
);

    // landed cells of this row
    logic [COLS-1:0] stored;

    // board starts empty
    // on merge the falling piece becomes permanent here
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            stored <= '0;
        end else if (merge) begin
            stored <= stored | cur_bits;
        end
    end

    // probe lands on something already stored
    assign hit = |(probe_bits & stored);

    // what the player sees in this row
    // stays the same through merge since cur_bits is still shown
    assign display_row = stored | cur_bits;

endmodule

// ==== verilog/tetris_pkg.sv ====
package tetris_pkg;

    // piece kinds as carried on the piece handshake
    // code 7 is left out on purpose, the renderer draws it as a line
    typedef enum logic [2:0] {
        // vertical bar, four tall
        LINE      = 3'd0,
        // 2x2 block
        SMASHBOY  = 3'd1,
        // bar with a foot to the right
        L_PIECE   = 3'd2,
        // bar with a foot to the left
        REVERSE_L = 3'd3,
        // upper pair shifted right
        S_PIECE   = 3'd4,
        // upper pair shifted left
        Z_PIECE   = 3'd5,
        // nub on top, three wide below
        T_PIECE   = 3'd6
    } piece_type_t;

    // rows a piece box can cover, the line is the tallest
    // also the margin on row counters so row + span never wraps
    localparam int PIECE_SPAN = 4;

endpackage

// ==== verilog/tetris_top.sv ====
`timescale 1ns/1ps

module tetris_top #(
    parameter int ROWS = 20,
    parameter int COLS = 10,
    localparam int ROW_W = $clog2(ROWS + tetris_pkg::PIECE_SPAN)
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      piece_valid,
    input  tetris_pkg::piece_type_t   piece_type,
    output logic                      piece_ready,
    input  logic                      drop,
    output logic [ROWS-1:0][COLS-1:0] display,
    output logic                      game_over
);
    import tetris_pkg::*;

    // controller to renderer
    piece_type_t              cur_type;
    piece_type_t              probe_type;
    logic [ROW_W-1:0]         cur_row;
    logic [ROW_W-1:0]         probe_row;
    logic                     piece_active;
    // renderer to rows
    logic [ROWS-1:0][COLS-1:0] cur_bits;
    logic [ROWS-1:0][COLS-1:0] probe_bits;
    logic                      probe_off_board;
    // rows to collector
    logic [ROWS-1:0]           row_hit;
    logic [COLS-1:0]           row_display [ROWS];
    // back to the controller
    logic                      blocked;
    logic                      merge;

    game_fsm #(.ROWS(ROWS)) u_fsm (
        .clk          (clk),
        .reset        (reset),
        .piece_valid  (piece_valid),
        .piece_type   (piece_type),
        .drop         (drop),
        .blocked      (blocked),
        .piece_ready  (piece_ready),
        .cur_type     (cur_type),
        .cur_row      (cur_row),
        .piece_active (piece_active),
        .probe_type   (probe_type),
        .probe_row    (probe_row),
        .merge        (merge),
        .game_over    (game_over)
    );

    piece_renderer #(.ROWS(ROWS), .COLS(COLS)) u_renderer (
        .cur_type        (cur_type),
        .cur_row         (cur_row),
        .piece_active    (piece_active),
        .probe_type      (probe_type),
        .probe_row       (probe_row),
        .cur_bits        (cur_bits),
        .probe_bits      (probe_bits),
        .probe_off_board (probe_off_board)
    );

    // one storage row per board row
    for (genvar r = 0; r < ROWS; r++) begin : gen_rows
        playfield_row #(.COLS(COLS)) u_row (
            .clk         (clk),
            .reset       (reset),
            .merge       (merge),
            .cur_bits    (cur_bits[r]),
            .probe_bits  (probe_bits[r]),
            .hit         (row_hit[r]),
            .display_row (row_display[r])
        );
    end

    landing_collector #(.ROWS(ROWS), .COLS(COLS)) u_collector (
        .row_hit         (row_hit),
        .probe_off_board (probe_off_board),
        .display_rows    (row_display),
        .blocked         (blocked),
        .display         (display)
    );

endmodule
